/* egr_port_array_adapt.f */
hdl/egr_pkg.sv
hdl/egr_port_ctrl.sv
hdl/egr_frame_fifo.sv
hdl/egr_width_conv.sv
hdl/egr_port_profile.sv
hdl/egr_port_array_adapt.sv
verif/tb_egr_port_array_adapt.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the egress adapter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_egr_port_array_adapt \
    -Mdir obj_dir \
    -f egr_port_array_adapt.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_egr_port_array_adapt > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "test passed" sim.log; then
    exit 0
fi
exit 1

/* verif/tb_egr_port_array_adapt.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the egress port array adapter
// Random frames per port checked against a byte queue model and assertions
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_egr_port_array_adapt import egr_pkg::*; ();

    localparam int NP = 2;
    localparam int FW = 16;

    // Rough cycle budget of each test
    localparam int RST_CYC    = 8;
    localparam int T1_CYC     = 300;
    localparam int T2_CYC     = 120;
    localparam int T3_CYC     = 500;
    localparam int T4_CYC     = 720;
    localparam int T5_CYC     = 10;
    localparam int T6_CYC     = 520;
    localparam int MAX_CYCLES =
        (RST_CYC + T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC + T6_CYC) * 4;

    logic          clk_i = 1'b0;
    logic          rst_n_i;
    logic [NP-1:0] in_valid;
    in_beat_t      in_beat [NP];
    logic [NP-1:0] enable;
    logic [NP-1:0] clear;
    logic [NP-1:0] out_valid;
    out_beat_t     out_beat [NP];
    logic [NP-1:0] out_ready;
    logic [NP-1:0] connected;
    logic [NP-1:0] drop;
    egr_counts_t   counts [NP];

    // Expected bytes as {end of beat, last, data}
    logic [9:0]    exp_q [NP][$];
    int            beats_wr [NP];
    int            beats_started [NP];
    logic          beat_open [NP];
    int            exp_drops [NP];
    int            drops_seen [NP];
    egr_counts_t   tally [NP];
    int            ready_mode [NP];
    int            errors;
    int            err_mark;
    int            tests;
    int            cycles;

    always #2 clk_i = ~clk_i;

    egr_port_array_adapt #(
        .NUM_PORTS   ( NP        ),
        .FIFO_WORDS  ( FW        )
    ) DUT (
        .clk_i       ( clk_i     ),
        .rst_n_i     ( rst_n_i   ),
        .in_valid_i  ( in_valid  ),
        .in_beat_i   ( in_beat   ),
        .enable_i    ( enable    ),
        .clear_i     ( clear     ),
        .out_valid_o ( out_valid ),
        .out_beat_o  ( out_beat  ),
        .out_ready_i ( out_ready ),
        .connected_o ( connected ),
        .drop_o      ( drop      ),
        .counts_o    ( counts    )
    );

    ////////////////////////////////////////////////////////////////////////////
    // Ready mode 0 holds low, 1 holds high and 2 is random

    always @(posedge clk_i) begin
        #1;
        for (int p = 0; p < NP; p++) begin
            case (ready_mode[p])
                0:       out_ready[p] = 1'b0;
                1:       out_ready[p] = 1'b1;
                default: out_ready[p] = 1'($urandom_range(1));
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Byte monitor and counter tallies

    always @(posedge clk_i) begin
        logic [9:0] e;
        logic       popped;
        if (rst_n_i) begin
            for (int p = 0; p < NP; p++) begin
                popped = 1'b0;
                // First sight of a beat means it left the FIFO
                if (out_valid[p] && !beat_open[p]) begin
                    beats_started[p]++;
                    beat_open[p] = 1'b1;
                end
                if (out_valid[p] && out_ready[p]) begin
                    if (exp_q[p].size() == 0) begin
                        $display("%0t ns: port %0d sent a byte that was not expected",
                                 $time, p);
                        errors++;
                    end else begin
                        e      = exp_q[p].pop_front();
                        popped = 1'b1;
                        if (out_beat[p].data !== e[7:0] || out_beat[p].last !== e[8]) begin
                            $display("MISMATCH at %0t ns: out_beat_o[%0d] expected %03h actual %03h",
                                     $time, p, e[8:0], out_beat[p]);
                            errors++;
                        end
                        if (e[9]) begin
                            beat_open[p] = 1'b0;
                        end
                    end
                end
                if (drop[p]) begin
                    drops_seen[p]++;
                end
                if (clear[p]) begin
                    tally[p] = '0;
                end else if (enable[p]) begin
                    // Bytes and frames come from the model's own queue entries
                    if (popped) begin
                        tally[p].bytes += 1;
                        if (e[8]) begin
                            tally[p].frames += 1;
                        end
                    end
                    if (out_valid[p] && !out_ready[p]) begin
                        tally[p].stalls += 1;
                    end
                    if (drop[p]) begin
                        tally[p].drops += 1;
                    end
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("test failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Assertions

    for (genvar g = 0; g < NP; g++) begin : g_chk
        assert property (@(posedge clk_i) disable iff (!rst_n_i)
            out_valid[g] && !out_ready[g] |=> out_valid[g] && $stable(out_beat[g]))
        else begin
            $display("%0t ns: port %0d output byte moved while stalled", $time, g);
            errors++;
        end

        assert property (@(posedge clk_i) disable iff (!rst_n_i)
            drop[g] |-> in_valid[g] && in_beat[g].last)
        else begin
            $display("%0t ns: port %0d drop pulse away from a last beat", $time, g);
            errors++;
        end

        // Open frame keeps the port connected whatever enable does
        assert property (@(posedge clk_i) disable iff (!rst_n_i)
            connected[g] && in_valid[g] && !in_beat[g].last |=> connected[g])
        else begin
            $display("%0t ns: port %0d disconnected inside a frame", $time, g);
            errors++;
        end

        assert property (@(posedge clk_i) disable iff (!rst_n_i)
            connected[g] && !enable[g] && in_valid[g] && in_beat[g].last |=> !connected[g])
        else begin
            $display("%0t ns: port %0d stayed connected after a disabled frame", $time, g);
            errors++;
        end

        assert property (@(posedge clk_i) disable iff (!rst_n_i)
            clear[g] |=> counts[g] == '0)
        else begin
            $display("%0t ns: port %0d counts not zero after clear", $time, g);
            errors++;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers

    function automatic in_keep_t keep_of(input int n);
        return in_keep_t'((5'd1 << n) - 5'd1);
    endfunction

    task automatic check_val(input string sig, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        if (act_v !== exp_v) begin
            $display("MISMATCH at %0t ns: %s expected %0h actual %0h",
                     $time, sig, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic check_counts(input int p, input egr_counts_t exp_c);
        check_val($sformatf("counts_o[%0d].frames", p), exp_c.frames, counts[p].frames);
        check_val($sformatf("counts_o[%0d].bytes", p), exp_c.bytes, counts[p].bytes);
        check_val($sformatf("counts_o[%0d].stalls", p), exp_c.stalls, counts[p].stalls);
        check_val($sformatf("counts_o[%0d].drops", p), exp_c.drops, counts[p].drops);
    endtask

    task automatic idle(input int n);
        for (int k = 0; k < n; k++) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    // Sends len beats and clears enable with beat off_at when in range
    task automatic send_frame(input int p, input int len, input bit wait_room,
                              input int off_at);
        int       n;
        bit       keep_frame;
        in_beat_t b;
        if (wait_room) begin
            while (beats_wr[p] - beats_started[p] + len > FW) begin
                @(posedge clk_i);
                #1;
            end
        end
        keep_frame = enable[p] && (beats_wr[p] - beats_started[p] + len <= FW);
        if (enable[p] && !keep_frame) begin
            exp_drops[p]++;
        end
        if (keep_frame) begin
            beats_wr[p] += len;
        end
        for (int i = 0; i < len; i++) begin
            n      = (i == len - 1) ? 1 + int'($urandom_range(3)) : 4;
            b.data = $urandom;
            b.keep = keep_of(n);
            b.last = (i == len - 1);
            if (keep_frame) begin
                for (int j = 0; j < n; j++) begin
                    exp_q[p].push_back({(j == n - 1), b.last && (j == n - 1),
                                        b.data[j*8 +: 8]});
                end
            end
            in_valid[p] = 1'b1;
            in_beat[p]  = b;
            if (i == off_at) begin
                enable[p] = 1'b0;
            end
            @(posedge clk_i);
            #1;
        end
        in_valid[p] = 1'b0;
    endtask

    task automatic traffic(input int p, input int nframes, input bit wait_room,
                           input int gap);
        for (int i = 0; i < nframes; i++) begin
            send_frame(p, 1 + int'($urandom_range(5)), wait_room, -1);
            idle(gap);
        end
    endtask

    task automatic wait_drain(input int p);
        while (exp_q[p].size() != 0) begin
            @(posedge clk_i);
            #1;
        end
        idle(1);
    endtask

    // First byte of a frame into an empty port is due two cycles after last
    task automatic check_latency(input int p);
        send_frame(p, 1 + int'($urandom_range(5)), 1'b1, -1);
        check_val($sformatf("out_valid_o[%0d] one cycle after last", p), 0, out_valid[p]);
        idle(1);
        check_val($sformatf("out_valid_o[%0d] two cycles after last", p), 1, out_valid[p]);
        wait_drain(p);
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == err_mark) begin
            $display("[%0d] %s : ok", tests, name);
        end else begin
            $display("[%0d] %s : %0d errors", tests, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        egr_counts_t snap;
        void'($urandom(67));
        rst_n_i   = 1'b0;
        in_valid  = '0;
        enable    = '1;
        clear     = '0;
        out_ready = '1;
        for (int p = 0; p < NP; p++) begin
            in_beat[p]    = '0;
            ready_mode[p] = 1;
            tally[p]      = '0;
            beat_open[p]  = 1'b0;
        end
        repeat (RST_CYC) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        idle(3);

        // In-order bytes and output latency
        fork
            begin
                check_latency(0);
                traffic(0, 8, 1'b1, 0);
            end
            begin
                check_latency(1);
                traffic(1, 8, 1'b1, 0);
            end
        join
        wait_drain(0);
        wait_drain(1);
        for (int p = 0; p < NP; p++) begin
            check_val($sformatf("connected_o[%0d] while enabled", p), 1, connected[p]);
        end
        finish_test("data order and latency");

        // Enable falls inside a frame on port 0
        send_frame(0, 5, 1'b1, 2);
        check_val("connected_o[0] after last", 0, connected[0]);
        send_frame(0, 4, 1'b1, -1);
        send_frame(0, 1, 1'b1, -1);
        idle(10);
        check_val("connected_o[0] while disabled", 0, connected[0]);
        enable[0] = 1'b1;
        idle(2);
        check_val("connected_o[0] after enable", 1, connected[0]);
        wait_drain(0);
        finish_test("enable on frame boundaries");

        // Overflow with the output stalled
        clear = '1;
        idle(1);
        clear = '0;
        ready_mode[0] = 0;
        ready_mode[1] = 0;
        idle(2);
        fork
            traffic(0, 8, 1'b0, 3);
            traffic(1, 8, 1'b0, 3);
        join
        for (int p = 0; p < NP; p++) begin
            check_val($sformatf("drop_o[%0d] pulses", p), exp_drops[p], drops_seen[p]);
            ready_mode[p] = 1;
        end
        wait_drain(0);
        wait_drain(1);
        finish_test("frame drops on overflow");

        // Random ready with counters running since the clear above
        ready_mode[0] = 2;
        ready_mode[1] = 2;
        fork
            traffic(0, 12, 1'b1, 0);
            traffic(1, 12, 1'b1, 0);
        join
        wait_drain(0);
        wait_drain(1);
        ready_mode[0] = 1;
        ready_mode[1] = 1;
        idle(2);
        check_counts(0, tally[0]);
        check_counts(1, tally[1]);
        finish_test("counters under random ready");

        // Clear one port only
        snap     = tally[1];
        clear[0] = 1'b1;
        idle(1);
        clear[0] = 1'b0;
        check_counts(0, '0);
        check_counts(1, snap);
        finish_test("per-port clear");

        // Port 0 stalled and overflowing beside clean port 1 traffic
        ready_mode[0] = 0;
        idle(2);
        snap.drops = cnt_t'(drops_seen[1]);
        fork
            traffic(0, 10, 1'b0, 3);
            begin
                for (int i = 0; i < 3; i++) begin
                    check_latency(1);
                end
            end
        join
        check_val("drop_o[0] pulses", exp_drops[0], drops_seen[0]);
        check_val("drop_o[1] pulses", snap.drops, drops_seen[1]);
        ready_mode[0] = 1;
        wait_drain(0);
        finish_test("port independence");

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* hdl/egr_port_array_adapt.sv */
////////////////////////////////////////////////////////////////////////////
// Egress port array adapter
// Gate, frame buffer, width converter and counters for each port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module egr_port_array_adapt import egr_pkg::*; #(
    parameter int NUM_PORTS  = 2,
    parameter int FIFO_WORDS = 16
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic [NUM_PORTS-1:0] in_valid_i,
    input  in_beat_t             in_beat_i [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] enable_i,
    input  logic [NUM_PORTS-1:0] clear_i,
    output logic [NUM_PORTS-1:0] out_valid_o,
    output out_beat_t            out_beat_o [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] out_ready_i,
    output logic [NUM_PORTS-1:0] connected_o,
    output logic [NUM_PORTS-1:0] drop_o,
    output egr_counts_t          counts_o [NUM_PORTS]
);

    logic [NUM_PORTS-1:0] in_last;
    logic [NUM_PORTS-1:0] pass;

    ////////////////////////////////////////////////////////////////////////////
    // Shared gate control

    egr_port_ctrl #(
        .NUM_PORTS   ( NUM_PORTS   )
    ) u_ctrl (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .in_valid_i  ( in_valid_i  ),
        .in_last_i   ( in_last     ),
        .enable_i    ( enable_i    ),
        .pass_o      ( pass        ),
        .connected_o ( connected_o )
    );

    ////////////////////////////////////////////////////////////////////////////
    // Per-port datapath

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        logic     fifo_valid;
        in_beat_t fifo_beat;
        logic     fifo_ready;

        assign in_last[p] = in_beat_i[p].last;

        egr_frame_fifo #(
            .FIFO_WORDS ( FIFO_WORDS                 )
        ) u_fifo (
            .clk_i      ( clk_i                      ),
            .rst_n_i    ( rst_n_i                    ),
            .wr_en_i    ( in_valid_i[p] & pass[p]    ),
            .wr_beat_i  ( in_beat_i[p]               ),
            .rd_valid_o ( fifo_valid                 ),
            .rd_beat_o  ( fifo_beat                  ),
            .rd_ready_i ( fifo_ready                 ),
            .drop_o     ( drop_o[p]                  )
        );

        egr_width_conv u_conv (
            .clk_i       ( clk_i          ),
            .rst_n_i     ( rst_n_i        ),
            .in_valid_i  ( fifo_valid     ),
            .in_beat_i   ( fifo_beat      ),
            .in_ready_o  ( fifo_ready     ),
            .out_valid_o ( out_valid_o[p] ),
            .out_beat_o  ( out_beat_o[p]  ),
            .out_ready_i ( out_ready_i[p] )
        );

        egr_port_profile u_profile (
            .clk_i       ( clk_i                  ),
            .rst_n_i     ( rst_n_i                ),
            .enable_i    ( enable_i[p]            ),
            .clear_i     ( clear_i[p]             ),
            .out_valid_i ( out_valid_o[p]         ),
            .out_ready_i ( out_ready_i[p]         ),
            .out_last_i  ( out_beat_o[p].last     ),
            .drop_i      ( drop_o[p]              ),
            .counts_o    ( counts_o[p]            )
        );
    end

endmodule

`default_nettype wire

/* hdl/egr_port_profile.sv */
////////////////////////////////////////////////////////////////////////////
// Egress port counters
// Frames, bytes, stall cycles and buffer drops, cleared by software
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module egr_port_profile import egr_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        enable_i,
    input  logic        clear_i,
    input  logic        out_valid_i,
    input  logic        out_ready_i,
    input  logic        out_last_i,
    input  logic        drop_i,
    output egr_counts_t counts_o
);

    egr_counts_t counts_q;
    logic        hs;

    // Holds at all ones rather than wrapping
    function automatic cnt_t sat_add(cnt_t val, cnt_t inc);
        logic [$bits(cnt_t):0] sum;
        sum = {1'b0, val} + {1'b0, inc};
        return sum[$bits(cnt_t)] ? '1 : sum[$bits(cnt_t)-1:0];
    endfunction

    assign hs = out_valid_i && out_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || clear_i) begin
            counts_q <= '0;
        end else if (enable_i) begin
            if (hs) begin
                counts_q.bytes <= sat_add(counts_q.bytes, cnt_t'(EGR_OUT_BYTES));
            end
            if (hs && out_last_i) begin
                counts_q.frames <= sat_add(counts_q.frames, cnt_t'(1));
            end
            if (out_valid_i && !out_ready_i) begin
                counts_q.stalls <= sat_add(counts_q.stalls, cnt_t'(1));
            end
            if (drop_i) begin
                counts_q.drops <= sat_add(counts_q.drops, cnt_t'(1));
            end
        end
    end

    assign counts_o = counts_q;

endmodule

`default_nettype wire

/* hdl/egr_width_conv.sv */
////////////////////////////////////////////////////////////////////////////
// Egress width converter, 4 bytes down to 1 byte per beat
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module egr_width_conv import egr_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      in_valid_i,
    input  in_beat_t  in_beat_i,
    output logic      in_ready_o,
    output logic      out_valid_o,
    output out_beat_t out_beat_o,
    input  logic      out_ready_i
);

    localparam int RATIO = EGR_IN_BYTES / EGR_OUT_BYTES;
    localparam int IDX_W = $clog2(RATIO);

    logic             busy_q;
    in_beat_t         beat_q;
    logic [IDX_W-1:0] idx_q;
    logic             last_byte;

    // Keep is contiguous, so the next clear bit ends the beat
    always_comb begin
        last_byte = 1'b1;
        if (idx_q != IDX_W'(RATIO - 1)) begin
            last_byte = !beat_q.keep[idx_q + 1'b1];
        end
    end

    assign out_valid_o     = busy_q;
    assign out_beat_o.data = beat_q.data[idx_q*8 +: 8];
    assign out_beat_o.last = beat_q.last && last_byte;

    // Next beat may load as the final byte leaves
    assign in_ready_o = !busy_q || (out_ready_i && last_byte);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            idx_q  <= '0;
        end else if (in_valid_i && in_ready_o) begin
            busy_q <= 1'b1;
            idx_q  <= '0;
        end else if (busy_q && out_ready_i) begin
            if (last_byte) begin
                busy_q <= 1'b0;
            end
            idx_q <= idx_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o) begin
            beat_q <= in_beat_i;
        end
    end

endmodule

`default_nettype wire

/* hdl/egr_frame_fifo.sv */
////////////////////////////////////////////////////////////////////////////
// Egress frame FIFO
// Commits whole frames and drops frames that do not fit
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module egr_frame_fifo import egr_pkg::*; #(
    parameter int FIFO_WORDS = 16
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     wr_en_i,
    input  in_beat_t wr_beat_i,
    output logic     rd_valid_o,
    output in_beat_t rd_beat_o,
    input  logic     rd_ready_i,
    output logic     drop_o
);

    localparam int AW    = $clog2(FIFO_WORDS);
    localparam int PTR_W = AW + 1;

    in_beat_t mem [FIFO_WORDS];

    // Extra pointer bit tells full from empty
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_com_q;
    logic [PTR_W-1:0] wr_spec_q;

    // Set once a beat of the open frame was lost
    logic             ovf_q;

    logic             full;
    logic             discard;
    logic             do_write;
    logic             do_read;

    ////////////////////////////////////////////////////////////////////////////
    // Write side

    assign full     = (wr_spec_q - rd_ptr_q) == PTR_W'(FIFO_WORDS);
    assign discard  = wr_en_i && (ovf_q || full);
    assign do_write = wr_en_i && !discard;

    // One pulse per lost frame, on its last beat
    assign drop_o = discard && wr_beat_i.last;

    always_ff @(posedge clk_i) begin
        if (do_write) begin
            mem[wr_spec_q[AW-1:0]] <= wr_beat_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_com_q  <= '0;
            wr_spec_q <= '0;
            ovf_q     <= 1'b0;
        end else if (discard) begin
            if (wr_beat_i.last) begin
                // Rewind over the partial frame
                wr_spec_q <= wr_com_q;
                ovf_q     <= 1'b0;
            end else begin
                ovf_q     <= 1'b1;
            end
        end else if (do_write) begin
            wr_spec_q <= wr_spec_q + 1'b1;
            if (wr_beat_i.last) begin
                wr_com_q <= wr_spec_q + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read side, committed frames only

    assign rd_valid_o = (rd_ptr_q != wr_com_q);
    assign rd_beat_o  = mem[rd_ptr_q[AW-1:0]];
    assign do_read    = rd_valid_o && rd_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_ptr_q <= '0;
        end else if (do_read) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hdl/egr_port_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// Egress port gate control
// Per-port FSM that passes or drops whole frames by software enable
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module egr_port_ctrl import egr_pkg::*; #(
    parameter int NUM_PORTS = 2
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic [NUM_PORTS-1:0] in_valid_i,
    input  logic [NUM_PORTS-1:0] in_last_i,
    input  logic [NUM_PORTS-1:0] enable_i,
    output logic [NUM_PORTS-1:0] pass_o,
    output logic [NUM_PORTS-1:0] connected_o
);

    gate_state_t state_q [NUM_PORTS];
    gate_state_t state_d [NUM_PORTS];

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            state_d[p] = state_q[p];
            case (state_q[p])
                GATE_IDLE_OFF, GATE_IDLE_ON: begin
                    // First beat of a multi-beat frame opens the gate decision
                    if (in_valid_i[p] && !in_last_i[p]) begin
                        state_d[p] = (state_q[p] == GATE_IDLE_ON) ? GATE_PASS : GATE_DROP;
                    end else begin
                        state_d[p] = enable_i[p] ? GATE_IDLE_ON : GATE_IDLE_OFF;
                    end
                end
                GATE_PASS, GATE_DROP: begin
                    // Frame closes on last, then follow enable again
                    if (in_valid_i[p] && in_last_i[p]) begin
                        state_d[p] = enable_i[p] ? GATE_IDLE_ON : GATE_IDLE_OFF;
                    end
                end
                default: state_d[p] = GATE_IDLE_OFF;
            endcase

            pass_o[p] = (state_q[p] == GATE_PASS) ||
                        ((state_q[p] == GATE_IDLE_ON) && in_valid_i[p]);
            connected_o[p] = (state_q[p] == GATE_IDLE_ON) || (state_q[p] == GATE_PASS);
        end
    end

    always_ff @(posedge clk_i) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (!rst_n_i) begin
                state_q[p] <= GATE_IDLE_OFF;
            end else begin
                state_q[p] <= state_d[p];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/egr_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Egress adapter shared definitions
// Bus widths, beat structs, counter types and gate states
////////////////////////////////////////////////////////////////////////////

package egr_pkg;

    // Fixed bus widths, 4 bytes in and 1 byte out
    localparam int EGR_IN_BYTES  = 4;
    localparam int EGR_OUT_BYTES = 1;

    typedef logic [7:0]              byte_t;
    typedef logic [EGR_IN_BYTES-1:0] in_keep_t;

    // Input beat, byte 0 in the low data bits
    typedef struct packed {
        logic                        last;
        in_keep_t                    keep;
        logic [EGR_IN_BYTES*8-1:0]   data;
    } in_beat_t;

    // Output beat toward the physical port
    typedef struct packed {
        logic  last;
        byte_t data;
    } out_beat_t;

    typedef logic [31:0] cnt_t;

    typedef struct packed {
        cnt_t frames;
        cnt_t bytes;
        cnt_t stalls;
        cnt_t drops;
    } egr_counts_t;

    // Frame-boundary gate
    typedef enum logic [1:0] {
        GATE_IDLE_OFF,
        GATE_IDLE_ON,
        GATE_PASS,
        GATE_DROP
    } gate_state_t;

endpackage
